// File: hw/cpu6502_consts.svh
`ifndef CPU6502_CONSTS_SVH
`define CPU6502_CONSTS_SVH

// Reset vector of the CPU
// Low byte at this address, high byte right after it
`define CPU_RESET_VECTOR 16'hFFFC

// Shared RAM geometry
// Only the low address bits decode, so the 64 KB space mirrors the array
`define RAM_ADDR_BITS 12
`define RAM_BYTES 4096

// Longest block that one DMA command can copy
// Also sets the width of the length field
`define DMA_MAX_LEN 255

`endif

// File: hw/bus_pkg.sv
`include "cpu6502_consts.svh"

package bus_pkg;

    typedef logic [15:0] addr_t;                            // CPU-visible address
    typedef logic [7:0]  byte_t;                            // One data byte
    typedef logic [$clog2(`DMA_MAX_LEN + 1) - 1:0] dma_len_t; // Copy length in bytes

    // Owner of the current bus slot
    typedef enum logic {
        BUS_CPU = 1'b0,                                     // Even slots
        BUS_DMA = 1'b1                                      // Odd slots
    } master_e;

    typedef struct packed {
        logic  rw;                                          // 1 = read, 0 = write
        addr_t addr;
        byte_t wdata;                                       // Ignored on reads
    } bus_req_t;

    // One access as the RAM saw it
    typedef struct packed {
        master_e master;
        logic    rw;
        addr_t   addr;
        byte_t   data;                                      // Read data or write data
    } bus_trace_t;

    typedef struct packed {
        addr_t    src;                                      // First source byte
        addr_t    dst;                                      // First destination byte
        dma_len_t len;                                      // Zero finishes at once
    } dma_cmd_t;

endpackage

// File: hw/cpu6502_pkg.sv
package cpu6502_pkg;

    // Top-level CPU sequencing
    typedef enum logic {
        ST_RESET_VECTOR = 1'b0,                             // Fetch PC from FFFC/FFFD
        ST_EXECUTE      = 1'b1                              // Fetch and run opcodes
    } cpu_state_e;

    // Implemented opcodes, 6502 encodings
    // Anything else runs as a single-byte NOP
    typedef enum logic [7:0] {
        OP_NOP     = 8'hEA,                                 // 1 byte
        OP_LDA_IMM = 8'hA9,                                 // 2 bytes
        OP_STA_ABS = 8'h8D,                                 // 3 bytes plus a write
        OP_JMP_ABS = 8'h4C                                  // 3 bytes
    } opcode_e;

    // Timing step inside an instruction
    // Counts CPU slots, not clocks
    typedef logic [2:0] tcu_t;

endpackage

// File: hw/cpu6502.sv
`timescale 1ns/1ns
`include "cpu6502_consts.svh"

module cpu6502
    import bus_pkg::*;
    import cpu6502_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_slot,                  // CPU owns the bus this cycle
    input  byte_t      i_rd_data,               // Valid in our slot only

    output bus_req_t   o_req,                   // Read unless STA write step
    output addr_t      o_debug_pc,
    output byte_t      o_debug_ir,
    output byte_t      o_debug_a,
    output cpu_state_e o_debug_state
);

localparam tcu_t TCU_FETCH   = 3'd0;            // Opcode fetch
localparam tcu_t TCU_OPER_LO = 3'd1;            // Immediate or address low
localparam tcu_t TCU_OPER_HI = 3'd2;            // Address high
localparam tcu_t TCU_WRITE   = 3'd3;            // STA store cycle

cpu_state_e r_state;
tcu_t       r_tcu;                              // Step within instruction
addr_t      r_pc;                               // Program counter
byte_t      r_ir;                               // Instruction register
byte_t      r_a;                                // Accumulator
addr_t      r_oper;                             // Absolute operand latch
addr_t      vector_addr;                        // FFFC then FFFD

assign vector_addr = addr_t'(`CPU_RESET_VECTOR) + addr_t'(r_tcu);

// Sequencing, PC and IR
always_ff @(posedge i_clk)
begin
    if (!i_reset_n)
    begin
        r_state <= ST_RESET_VECTOR;
        r_tcu   <= TCU_FETCH;
        r_pc    <= '0;
        r_ir    <= OP_NOP;
    end
    else if (i_slot)                            // Steps advance on own slots only
    begin
        case (r_state)
            ST_RESET_VECTOR:
            begin
                if (r_tcu == TCU_FETCH)
                begin
                    r_pc[7:0] <= i_rd_data;     // Vector low byte
                    r_tcu     <= TCU_OPER_LO;
                end
                else
                begin
                    r_pc[15:8] <= i_rd_data;    // Vector high byte
                    r_state    <= ST_EXECUTE;
                    r_tcu      <= TCU_FETCH;
                end
            end

            ST_EXECUTE:
            begin
                case (r_tcu)
                    TCU_FETCH:
                    begin
                        r_ir <= i_rd_data;
                        r_pc <= r_pc + 16'd1;
                        case (i_rd_data)        // Decode straight off the bus
                            OP_LDA_IMM,
                            OP_STA_ABS,
                            OP_JMP_ABS: r_tcu <= TCU_OPER_LO;
                            default:    r_tcu <= TCU_FETCH;     // NOP and unknowns
                        endcase
                    end

                    TCU_OPER_LO:
                    begin
                        r_pc <= r_pc + 16'd1;
                        if (r_ir == OP_LDA_IMM)
                            r_tcu <= TCU_FETCH; // LDA done
                        else
                            r_tcu <= TCU_OPER_HI;
                    end

                    TCU_OPER_HI:
                    begin
                        if (r_ir == OP_JMP_ABS)
                        begin
                            r_pc  <= {i_rd_data, r_oper[7:0]};  // Jump target
                            r_tcu <= TCU_FETCH;
                        end
                        else
                        begin
                            r_pc  <= r_pc + 16'd1;
                            r_tcu <= TCU_WRITE;                 // STA store next
                        end
                    end

                    default:
                        r_tcu <= TCU_FETCH;     // After the STA write
                endcase
            end

            default:
                r_state <= ST_RESET_VECTOR;
        endcase
    end
end

// Accumulator and operand latch
always_ff @(posedge i_clk)
begin
    if (i_slot && r_state == ST_EXECUTE)
    begin
        if (r_tcu == TCU_OPER_LO)
        begin
            if (r_ir == OP_LDA_IMM)
                r_a <= i_rd_data;               // Immediate load
            else
                r_oper[7:0] <= i_rd_data;
        end
        else if (r_tcu == TCU_OPER_HI)
        begin
            r_oper[15:8] <= i_rd_data;
        end
    end
end

// Bus request for our next slot
always_comb
begin
    o_req.rw    = 1'b1;                         // Read by default
    o_req.addr  = r_pc;
    o_req.wdata = r_a;                          // Only STA stores
    if (r_state == ST_RESET_VECTOR)
    begin
        o_req.addr = vector_addr;
    end
    else if (r_tcu == TCU_WRITE)
    begin
        o_req.rw   = 1'b0;
        o_req.addr = r_oper;                    // STA destination
    end
end

assign o_debug_pc    = r_pc;
assign o_debug_ir    = r_ir;
assign o_debug_a     = r_a;
assign o_debug_state = r_state;

endmodule

// File: hw/dma_copier.sv
`timescale 1ns/1ns

module dma_copier
    import bus_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset_n,
    input  logic     i_slot,                    // DMA owns the bus this cycle
    input  logic     i_start,                   // One-cycle command strobe
    input  dma_cmd_t i_cmd,
    input  byte_t    i_rd_data,

    output bus_req_t o_req,
    output logic     o_done,                    // Pulse after last write
    output logic     o_busy
);

logic     r_busy;
logic     r_phase;                              // 0 = read source, 1 = write dest
logic     r_done;
dma_len_t r_count;                              // Bytes still to copy
addr_t    r_src;
addr_t    r_dst;
byte_t    r_buf;                                // Byte in flight

always_ff @(posedge i_clk)
begin
    if (!i_reset_n)
    begin
        r_busy  <= 1'b0;
        r_phase <= 1'b0;
        r_done  <= 1'b0;
        r_count <= '0;
    end
    else
    begin
        r_done <= 1'b0;
        if (!r_busy)
        begin
            if (i_start)                        // Starts while busy are dropped
            begin
                r_count <= i_cmd.len;
                r_phase <= 1'b0;
                if (i_cmd.len == '0)
                    r_done <= 1'b1;             // Empty copy, finish now
                else
                    r_busy <= 1'b1;
            end
        end
        else if (i_slot)
        begin
            r_phase <= ~r_phase;
            if (r_phase)                        // Write slot ends one byte
            begin
                r_count <= r_count - dma_len_t'(1);
                if (r_count == dma_len_t'(1))
                begin
                    r_busy <= 1'b0;
                    r_done <= 1'b1;
                end
            end
        end
    end
end

// Pointers and data buffer
always_ff @(posedge i_clk)
begin
    if (!r_busy && i_start)
    begin
        r_src <= i_cmd.src;
        r_dst <= i_cmd.dst;
    end
    else if (r_busy && i_slot)
    begin
        if (!r_phase)
        begin
            r_buf <= i_rd_data;                 // Capture source byte
            r_src <= r_src + 16'd1;
        end
        else
        begin
            r_dst <= r_dst + 16'd1;
        end
    end
end

always_comb
begin
    o_req.rw    = 1'b1;
    o_req.addr  = '0;                           // Idle dummy read
    o_req.wdata = r_buf;
    if (r_busy)
    begin
        o_req.rw   = ~r_phase;
        o_req.addr = r_phase ? r_dst : r_src;
    end
end

assign o_done = r_done;
assign o_busy = r_busy;

endmodule

// File: hw/bus_slot_arbiter.sv
`timescale 1ns/1ns

module bus_slot_arbiter
    import bus_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  bus_req_t   i_cpu_req,
    input  bus_req_t   i_dma_req,
    input  byte_t      i_ram_rd_data,

    output logic       o_cpu_slot,              // Even cycles
    output logic       o_dma_slot,              // Odd cycles
    output bus_req_t   o_ram_req,
    output byte_t      o_rd_data,               // Shared read return
    output bus_trace_t o_trace
);

logic     r_slot;                               // 0 = CPU, 1 = DMA
master_e  owner;

// Fixed alternation, no grants
always_ff @(posedge i_clk)
begin
    if (!i_reset_n)
        r_slot <= 1'b0;                         // CPU goes first
    else
        r_slot <= ~r_slot;
end

assign owner      = r_slot ? BUS_DMA : BUS_CPU;
assign o_cpu_slot = ~r_slot;
assign o_dma_slot = r_slot;

assign o_ram_req = r_slot ? i_dma_req : i_cpu_req;
assign o_rd_data = i_ram_rd_data;               // Each master samples in own slot

// Trace carries the byte actually moved
always_comb
begin
    o_trace.master = owner;
    o_trace.rw     = o_ram_req.rw;
    o_trace.addr   = o_ram_req.addr;
    o_trace.data   = o_ram_req.rw ? i_ram_rd_data : o_ram_req.wdata;
end

endmodule

// File: hw/system_ram.sv
`timescale 1ns/1ns
`include "cpu6502_consts.svh"

module system_ram
    import bus_pkg::*;
(
    input  logic     i_clk,
    input  bus_req_t i_req,                     // Routed by the arbiter
    output byte_t    o_rd_data                  // Same-cycle read
);

byte_t mem [`RAM_BYTES];
logic [`RAM_ADDR_BITS - 1:0] idx;               // Upper address bits mirror

// Program, data and vectors
initial
begin
    $readmemh("tests/program.hex", mem);
end

assign idx       = i_req.addr[`RAM_ADDR_BITS - 1:0];
assign o_rd_data = mem[idx];

// Write lands at the slot's closing edge
always_ff @(posedge i_clk)
begin
    if (!i_req.rw)
        mem[idx] <= i_req.wdata;
end

endmodule

// File: hw/cpu6502_system.sv
`timescale 1ns/1ns

module cpu6502_system
    import bus_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_dma_start,
    input  dma_cmd_t   i_dma_cmd,

    output logic       o_dma_done,
    output logic       o_dma_busy,
    output bus_trace_t o_bus_trace,             // One access per cycle
    output addr_t      o_debug_pc,
    output byte_t      o_debug_a
);

logic     cpu_slot;
logic     dma_slot;
bus_req_t cpu_req;
bus_req_t dma_req;
bus_req_t ram_req;
byte_t    ram_rd_data;
byte_t    rd_data;                              // Return to both masters

cpu6502 u_cpu (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_slot        (cpu_slot),
    .i_rd_data     (rd_data),
    .o_req         (cpu_req),
    .o_debug_pc    (o_debug_pc),
    .o_debug_ir    (),
    .o_debug_a     (o_debug_a),
    .o_debug_state ()
);

dma_copier u_dma (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_slot    (dma_slot),
    .i_start   (i_dma_start),
    .i_cmd     (i_dma_cmd),
    .i_rd_data (rd_data),
    .o_req     (dma_req),
    .o_done    (o_dma_done),
    .o_busy    (o_dma_busy)
);

bus_slot_arbiter u_arb (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_cpu_req     (cpu_req),
    .i_dma_req     (dma_req),
    .i_ram_rd_data (ram_rd_data),
    .o_cpu_slot    (cpu_slot),
    .o_dma_slot    (dma_slot),
    .o_ram_req     (ram_req),
    .o_rd_data     (rd_data),
    .o_trace       (o_bus_trace)
);

system_ram u_ram (
    .i_clk     (i_clk),
    .i_req     (ram_req),
    .o_rd_data (ram_rd_data)
);

endmodule

// File: tests/tb_cpu6502_system.sv
`timescale 1ns/1ns
`include "cpu6502_consts.svh"

module tb_cpu6502_system
    import bus_pkg::*;
    import cpu6502_pkg::*;
();

localparam int NUM_CMDS = 8;

logic       clk;
logic       reset_n;
logic       dma_start;
dma_cmd_t   dma_cmd;
logic       dma_done;
logic       dma_busy;
bus_trace_t bus_trace;
addr_t      debug_pc;
byte_t      debug_a;

byte_t      model_mem [`RAM_BYTES];             // Expected RAM contents
cpu_state_e m_state;
tcu_t       m_step;
addr_t      m_pc;
addr_t      m_oper;
byte_t      m_ir;
byte_t      m_a;
logic       m_a_valid;                          // Set by first LDA
master_e    m_slot;                             // Owner of this cycle
logic       m_dma_busy;
logic       m_dma_phase;                        // 0 = read, 1 = write
dma_len_t   m_dma_count;
addr_t      m_src;
addr_t      m_dst;
byte_t      m_buf;
logic       m_done;                             // Done pulse due this cycle

bus_trace_t exp_acc;
int         done_seen = 0;
int         accepted_cmds = 0;
int         limit_cycles = 0;
logic       limit_ready = 1'b0;
integer     seed;
dma_cmd_t   cmds [NUM_CMDS];

cpu6502_system uut (
    .i_clk       (clk),
    .i_reset_n   (reset_n),
    .i_dma_start (dma_start),
    .i_dma_cmd   (dma_cmd),
    .o_dma_done  (dma_done),
    .o_dma_busy  (dma_busy),
    .o_bus_trace (bus_trace),
    .o_debug_pc  (debug_pc),
    .o_debug_a   (debug_a)
);

initial
begin
    clk = 1'b0;
    forever #2 clk = ~clk;                      // 4 ns period
end

initial
begin
    $readmemh("tests/program.hex", model_mem);  // Same image as the RAM
end

task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped");
endtask

task automatic report_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    abort_run();
endtask

task automatic reset_model();
    m_state     = ST_RESET_VECTOR;
    m_step      = '0;
    m_pc        = '0;
    m_a_valid   = 1'b0;
    m_slot      = BUS_CPU;                      // CPU slot comes first
    m_dma_busy  = 1'b0;
    m_dma_phase = 1'b0;
    m_done      = 1'b0;
endtask

// Expected access for the slot owner from the model state
function automatic bus_trace_t next_expected_access(input master_e who);
    bus_trace_t acc;
    acc.master = who;
    acc.rw     = 1'b1;
    acc.addr   = 16'h0000;                      // Idle DMA dummy read
    if (who == BUS_CPU)
    begin
        if (m_state == ST_RESET_VECTOR)
            acc.addr = `CPU_RESET_VECTOR + {13'd0, m_step};
        else if (m_step == 3'd3)
        begin
            acc.rw   = 1'b0;                    // STA store
            acc.addr = m_oper;
        end
        else
            acc.addr = m_pc;
    end
    else if (m_dma_busy)
    begin
        acc.rw   = ~m_dma_phase;
        acc.addr = m_dma_phase ? m_dst : m_src;
    end
    if (acc.rw)
        acc.data = model_mem[acc.addr[`RAM_ADDR_BITS - 1:0]];
    else
        acc.data = (who == BUS_CPU) ? m_a : m_buf;
    return acc;
endfunction

task automatic step_cpu_model(input byte_t d);
    if (m_state == ST_RESET_VECTOR)
    begin
        if (m_step == 3'd0)
        begin
            m_pc[7:0] = d;                      // Vector low first
            m_step    = 3'd1;
        end
        else
        begin
            m_pc[15:8] = d;
            m_state    = ST_EXECUTE;
            m_step     = 3'd0;
        end
    end
    else
    begin
        case (m_step)
            3'd0:
            begin
                m_ir   = d;
                m_pc   = m_pc + 16'd1;
                m_step = (d == OP_LDA_IMM || d == OP_STA_ABS || d == OP_JMP_ABS) ? 3'd1 : 3'd0;
            end
            3'd1:
            begin
                m_pc = m_pc + 16'd1;
                if (m_ir == OP_LDA_IMM)
                begin
                    m_a       = d;
                    m_a_valid = 1'b1;
                    m_step    = 3'd0;
                end
                else
                begin
                    m_oper[7:0] = d;
                    m_step      = 3'd2;
                end
            end
            3'd2:
            begin
                if (m_ir == OP_JMP_ABS)
                begin
                    m_pc   = {d, m_oper[7:0]};  // Next fetch from target
                    m_step = 3'd0;
                end
                else
                begin
                    m_pc         = m_pc + 16'd1;
                    m_oper[15:8] = d;
                    m_step       = 3'd3;
                end
            end
            default:
                m_step = 3'd0;                  // After the store
        endcase
    end
endtask

task automatic step_dma_model(input byte_t d);
    if (!m_dma_phase)
    begin
        m_buf = d;
        m_src = m_src + 16'd1;
    end
    else
    begin
        m_dst       = m_dst + 16'd1;
        m_dma_count = m_dma_count - dma_len_t'(1);
        if (m_dma_count == '0)
        begin
            m_dma_busy = 1'b0;
            m_done     = 1'b1;                  // Pulse in the next cycle
        end
    end
    m_dma_phase = ~m_dma_phase;
endtask

task automatic update_model(input bus_trace_t acc, input logic start, input dma_cmd_t cmd);
    logic was_busy;
    was_busy = m_dma_busy;
    m_done   = 1'b0;
    if (!acc.rw)
        model_mem[acc.addr[`RAM_ADDR_BITS - 1:0]] = acc.data;
    if (acc.master == BUS_CPU)
        step_cpu_model(acc.data);
    else if (m_dma_busy)
        step_dma_model(acc.data);
    if (!was_busy && start)                     // Strobes while busy are dropped
    begin
        m_src       = cmd.src;
        m_dst       = cmd.dst;
        m_dma_count = cmd.len;
        m_dma_phase = 1'b0;
        if (cmd.len == '0)
            m_done = 1'b1;
        else
            m_dma_busy = 1'b1;
    end
    m_slot = (m_slot == BUS_CPU) ? BUS_DMA : BUS_CPU;
endtask

// Comparer for the access that completes at this edge
always @(posedge clk)
begin
    if (!reset_n)
    begin
        reset_model();
    end
    else
    begin
        assert (bus_trace.master === m_slot)
        else report_error($sformatf("slot owner %0d, expected %0d", bus_trace.master, m_slot));
        exp_acc = next_expected_access(bus_trace.master);
        assert (bus_trace === exp_acc)
        else report_error($sformatf("access rw=%0d %h:%h, expected rw=%0d %h:%h",
                                   bus_trace.rw, bus_trace.addr, bus_trace.data,
                                   exp_acc.rw, exp_acc.addr, exp_acc.data));
        assert (dma_done === m_done)
        else report_error($sformatf("dma done %0b, expected %0b", dma_done, m_done));
        assert (dma_busy === m_dma_busy)
        else report_error($sformatf("dma busy %0b, expected %0b", dma_busy, m_dma_busy));
        assert (debug_pc === m_pc)
        else report_error($sformatf("program counter %h, expected %h", debug_pc, m_pc));
        if (m_a_valid)
        begin
            assert (debug_a === m_a)
            else report_error($sformatf("accumulator %h, expected %h", debug_a, m_a));
        end
        if (dma_done)
            done_seen++;
        update_model(exp_acc, dma_start, dma_cmd);
    end
end

// Sources in the data block 000-03F and destinations in the free block from 800
task automatic make_commands();
    logic [31:0] r;
    dma_len_t    len;
    int          lo;
    int          sum_len;
    sum_len = 0;
    for (int i = 0; i < NUM_CMDS; i++)
    begin
        r           = $random(seed);
        len         = (i == 3) ? dma_len_t'(0) : dma_len_t'(32'd1 + r[3:0]);
        if (i == 0)
            len     = dma_len_t'(32'd6 + r[3:0]);   // Reaches the CPU store at 005
        lo          = (i == 0) ? 0 : int'(r[9:4]) % (65 - int'(len));
        cmds[i].len = len;
        cmds[i].src = {r[31:28], 12'(lo)};      // Upper nibble mirrors
        cmds[i].dst = {r[27:24], 2'b10, r[19:10]};
        if (i == NUM_CMDS - 1)
        begin
            cmds[i].src = cmds[0].dst;          // Read back the first copy
            cmds[i].len = cmds[0].len;
            len         = cmds[0].len;
        end
        sum_len     = sum_len + int'(len);
    end
    limit_cycles = 200 + 5 * sum_len + 8 * NUM_CMDS + 100;
    limit_ready  = 1'b1;
endtask

task automatic issue_command(input int idx);
    logic [31:0] r;
    r = $random(seed);
    repeat (r[1:0]) @(negedge clk);             // Random gap
    dma_cmd   = cmds[idx];
    dma_start = 1'b1;
    accepted_cmds++;
    @(negedge clk);
    if (cmds[idx].len != '0 && idx % 2 == 0)
    begin
        dma_cmd.src = 16'h0010;                 // Second strobe while busy
        dma_cmd.dst = 16'h0C00;
        dma_cmd.len = dma_len_t'(5);
        @(negedge clk);
    end
    dma_start = 1'b0;
    while (done_seen != accepted_cmds)
        @(negedge clk);
endtask

initial
begin
    reset_n   = 1'b0;
    dma_start = 1'b0;
    dma_cmd   = '0;
    seed      = 32'h59d4;
    make_commands();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    repeat (40) @(negedge clk);                 // CPU runs alone first
    for (int i = 0; i < NUM_CMDS; i++)
        issue_command(i);
    repeat (60) @(negedge clk);
    if (done_seen == accepted_cmds && !dma_busy)
    begin
        $display("TEST RESULT: PASS");
        $finish;
    end
    else
        report_error($sformatf("%0d done pulses for %0d accepted commands",
                               done_seen, accepted_cmds));
end

initial
begin
    wait (limit_ready);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
    abort_run();
end

endmodule

// File: tests/program.hex
// RAM image for the CPU system, one hex byte per entry
// An @ line sets the byte address where the following entries load
@000
3C A7 19 E2 50 8B 04 F6 D1 2E 7A 95 63 C8 0F B4
27 E9 42 9D 11 6F C5 88 3A F0 5B 76 AE 0D 93 4C
B8 21 67 DA 05 7E C1 39 F4 8D 52 AB 16 E7 60 9F
CB 34 75 08 E1 4A 97 2C D6 13 89 F2 5E A4 3B 70
@100
EA          // 100 NOP
A9 5A       // 101 LDA #$5A
8D 05 10    // 103 STA $1005 into the data mirror
02          // 106 Unknown opcode
A9 C3       // 107 LDA #$C3
8D 05 10    // 109 STA $1005 again
FF          // 10C Unknown opcode
4C 00 F1    // 10D JMP $F100 back to the mirrored start
@FFC
00 01       // Reset vector low then high

// File: flist.f
+incdir+hw
hw/bus_pkg.sv
hw/cpu6502_pkg.sv
hw/cpu6502.sv
hw/dma_copier.sv
hw/bus_slot_arbiter.sv
hw/system_ram.sv
hw/cpu6502_system.sv
tests/tb_cpu6502_system.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the CPU system testbench with Verilator and runs it
# Exit status is the simulator's own, nonzero on any failed check

cd "$(dirname "$0")" || exit 1

TOP=tb_cpu6502_system
OBJ=obj_dir

verilator --binary --timing --assert \
    --top-module "$TOP" --Mdir "$OBJ" -o "sim_$TOP" \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
fi
exit $status
